// ==== include/apu_defines.svh ====
`ifndef APU_DEFINES_SVH
`define APU_DEFINES_SVH

// Number of cores sharing each unit
`define APU_NB_CORES    4

// Core index width
// Must cover APU_NB_CORES exactly so the round-robin pointer wraps
`define APU_TAG_W       2

// Operand and result width
`define APU_DATA_W      32

// Register stages in the multiplier
`define APU_MULT_STAGES 3

// One quotient bit per divider iteration
`define APU_DIV_CYCLES  32

`endif

// ==== project.f ====
+incdir+include
verilog/apu_op_pkg.sv
verilog/apu_route_pkg.sv
verilog/apu_dispatch.sv
verilog/apu_arbiter.sv
verilog/int_mult_unit.sv
verilog/int_div_unit.sv
verilog/apu_cluster.sv
verif/apu_cluster_checker.sv
verif/tb_apu_cluster.sv

// ==== verif/apu_cluster_checker.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_cluster_checker (
   input  logic                     clk,
   input  logic                     rst_n,
   // Core side
   input  apu_route_pkg::core_vec_t ack,
   input  apu_route_pkg::core_vec_t valid,
   input  apu_route_pkg::core_vec_t ready,
   input  logic [`APU_DATA_W-1:0]   result [`APU_NB_CORES-1:0],
   input  apu_route_pkg::core_vec_t status,
   // Per-class grant view
   input  apu_route_pkg::core_vec_t mult_req,
   input  apu_route_pkg::core_vec_t mult_ack,
   input  apu_route_pkg::core_vec_t div_req,
   input  apu_route_pkg::core_vec_t div_ack,
   // Multiplier output handshake
   input  logic                     mult_out_valid,
   input  logic                     mult_out_ready
);
   import apu_route_pkg::*;

   // Cycles the pipeline must advance after the accept edge
   localparam int MULT_HOLD = `APU_MULT_STAGES - 1;
   // Accept edge to valid for the divider
   localparam int DIV_LAT   = `APU_DIV_CYCLES + 1;

   // Bumped by every failing assertion
   int unsigned fail_cnt = 0;

   // Acked and result not yet taken
   core_vec_t   outst;
   // Grants to other cores while this core waits
   logic [2:0]  mult_skip [`APU_NB_CORES-1:0];
   logic [2:0]  div_skip  [`APU_NB_CORES-1:0];
   logic        mult_stall;

   assign mult_stall = mult_out_valid && !mult_out_ready;

   ////////////////////
   // Tracking state
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         outst <= '0;
         for (int i = 0; i < `APU_NB_CORES; i++) begin
            mult_skip[i] <= '0;
            div_skip[i]  <= '0;
         end
      end else begin
         // New ack keeps the bit set even on a same-cycle handover
         outst <= ack | (outst & ~(valid & ready));
         for (int i = 0; i < `APU_NB_CORES; i++) begin
            if (!mult_req[i] || mult_ack[i]) begin
               mult_skip[i] <= '0;
            end else if (|mult_ack) begin
               mult_skip[i] <= mult_skip[i] + 1'b1;
            end
            if (!div_req[i] || div_ack[i]) begin
               div_skip[i] <= '0;
            end else if (|div_ack) begin
               div_skip[i] <= div_skip[i] + 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Per-core properties
   ////////////////////

   for (genvar i = 0; i < `APU_NB_CORES; i++) begin : g_core

      // Only one request in flight per core
      a_no_double_issue: assert property (@(posedge clk) disable iff (!rst_n)
         ack[i] |-> (!outst[i] || (valid[i] && ready[i])))
      else begin
         $error("Core %0d acknowledged while its result is outstanding", i);
         fail_cnt = fail_cnt + 1;
      end

      // Result held until taken
      a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
         (valid[i] && !ready[i]) |=>
            (valid[i] && $stable(result[i]) && $stable(status[i])))
      else begin
         $error("Core %0d result changed or dropped before ready", i);
         fail_cnt = fail_cnt + 1;
      end

      // Pipeline latency when nothing stalls
      a_mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
         mult_ack[i] ##1 (!mult_stall)[*MULT_HOLD] |=> valid[i])
      else begin
         $error("Core %0d multiply result late", i);
         fail_cnt = fail_cnt + 1;
      end

      // Fixed iteration count
      a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
         div_ack[i] |-> ##DIV_LAT valid[i])
      else begin
         $error("Core %0d divide result not on time", i);
         fail_cnt = fail_cnt + 1;
      end

      // At most three other grants before this core's own
      a_mult_fair: assert property (@(posedge clk) disable iff (!rst_n)
         (mult_req[i] && |mult_ack) |-> (mult_ack[i] || mult_skip[i] < 3))
      else begin
         $error("Core %0d starved on the multiplier", i);
         fail_cnt = fail_cnt + 1;
      end

      a_div_fair: assert property (@(posedge clk) disable iff (!rst_n)
         (div_req[i] && |div_ack) |-> (div_ack[i] || div_skip[i] < 3))
      else begin
         $error("Core %0d starved on the divider", i);
         fail_cnt = fail_cnt + 1;
      end
   end

endmodule

bind apu_cluster apu_cluster_checker checker_inst (
   .clk            (clk),
   .rst_n          (rst_n),
   .ack            (ack),
   .valid          (valid),
   .ready          (ready),
   .result         (result),
   .status         (status),
   .mult_req       (mult_req),
   .mult_ack       (mult_ack),
   .div_req        (div_req),
   .div_ack        (div_ack),
   .mult_out_valid (mult_out_valid),
   .mult_out_ready (mult_out_ready)
);

// ==== verif/tb_apu_cluster.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module tb_apu_cluster;
   import apu_op_pkg::*;
   import apu_route_pkg::*;

   localparam int     CLK_PERIOD = 10;
   localparam int     NUM_TXN    = 200;
   // Forty cycles per transaction per core is ample
   localparam longint TIMEOUT_NS = longint'(NUM_TXN) * `APU_NB_CORES * 40 * CLK_PERIOD;

   logic                   clk;
   logic                   rst_n;
   core_vec_t              req;
   apu_class_e             apu_class [`APU_NB_CORES-1:0];
   apu_opcode_e            opcode    [`APU_NB_CORES-1:0];
   logic [`APU_DATA_W-1:0] operand_a [`APU_NB_CORES-1:0];
   logic [`APU_DATA_W-1:0] operand_b [`APU_NB_CORES-1:0];
   core_vec_t              ack;
   core_vec_t              valid;
   core_vec_t              ready;
   logic [`APU_DATA_W-1:0] result    [`APU_NB_CORES-1:0];
   core_vec_t              status;

   // Expected values per core, in issue order
   logic [`APU_DATA_W-1:0] exp_result [`APU_NB_CORES][$];
   logic                   exp_status [`APU_NB_CORES][$];

   int error_cnt = 0;
   int check_cnt = 0;

   apu_cluster apu_cluster_inst (.*);

   ////////////////////
   // Clock
   ////////////////////

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [`APU_DATA_W-1:0] expected_result(
      input apu_class_e             cls,
      input apu_opcode_e            op,
      input logic [`APU_DATA_W-1:0] a,
      input logic [`APU_DATA_W-1:0] b
   );
      logic [2*`APU_DATA_W-1:0] prod;
      prod = (2*`APU_DATA_W)'(a) * (2*`APU_DATA_W)'(b);
      if (cls == APU_CLASS_MULT) begin
         return (op == OP_HIGH) ? prod[2*`APU_DATA_W-1:`APU_DATA_W] : prod[`APU_DATA_W-1:0];
      end
      // Zero divisor gives all ones or the dividend
      if (b == '0) begin
         return (op == OP_HIGH) ? a : '1;
      end
      return (op == OP_HIGH) ? (a % b) : (a / b);
   endfunction

   function automatic logic expected_status(
      input apu_class_e             cls,
      input logic [`APU_DATA_W-1:0] b
   );
      return (cls == APU_CLASS_DIV) && (b == '0);
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////

   // Outputs must stay quiet while no core requests
   task automatic check_idle_outputs(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_cnt++;
         assert (ack === '0) else begin
            $display("ERROR %0t ack expected %b got %b", $time, 4'b0, ack);
            error_cnt++;
         end
         assert (valid === '0) else begin
            $display("ERROR %0t valid expected %b got %b", $time, 4'b0, valid);
            error_cnt++;
         end
         @(posedge clk);
         #1;
      end
   endtask

   // One core's request stream
   task automatic issue_requests(input int c);
      int                     gap;
      logic                   acked;
      apu_class_e             cls;
      apu_opcode_e            op;
      logic [`APU_DATA_W-1:0] a;
      logic [`APU_DATA_W-1:0] b;
      for (int t = 0; t < NUM_TXN; t++) begin
         // First two go out together to load both arbiters
         gap = (t < 2) ? 0 : $urandom_range(0, 4);
         if (t == 0) begin
            cls = APU_CLASS_MULT;
         end else if (t == 1) begin
            cls = APU_CLASS_DIV;
         end else begin
            cls = apu_class_e'($urandom_range(0, 1));
         end
         op = apu_opcode_e'($urandom_range(0, 1));
         a  = $urandom;
         b  = $urandom;
         if (cls == APU_CLASS_DIV) begin
            // Small divisors give wider quotients, some are zero
            if ($urandom_range(0, 7) == 0) begin
               b = '0;
            end else if ($urandom_range(0, 1) == 0) begin
               b = $urandom_range(1, 255);
            end
         end
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         req[c]       = 1'b1;
         apu_class[c] = cls;
         opcode[c]    = op;
         operand_a[c] = a;
         operand_b[c] = b;
         acked        = 1'b0;
         while (!acked) begin
            @(negedge clk);
            acked = ack[c];
            @(posedge clk);
            #1;
         end
         exp_result[c].push_back(expected_result(cls, op, a, b));
         exp_status[c].push_back(expected_status(cls, b));
         req[c] = 1'b0;
      end
   endtask

   // One core's result side with random back-pressure
   task automatic collect_results(input int c);
      int                     got;
      logic [`APU_DATA_W-1:0] exp_r;
      logic                   exp_s;
      got = 0;
      while (got < NUM_TXN) begin
         ready[c] = ($urandom_range(0, 3) != 0);
         @(negedge clk);
         if (valid[c] && ready[c]) begin
            if (exp_result[c].size() == 0) begin
               $display("Core %0d received a result with no request outstanding at %0t",
                        c, $time);
               error_cnt++;
            end else begin
               exp_r = exp_result[c].pop_front();
               exp_s = exp_status[c].pop_front();
               check_cnt++;
               assert (result[c] === exp_r) else begin
                  $display("ERROR %0t result[%0d] expected %h got %h",
                           $time, c, exp_r, result[c]);
                  error_cnt++;
               end
               assert (status[c] === exp_s) else begin
                  $display("ERROR %0t status[%0d] expected %b got %b",
                           $time, c, exp_s, status[c]);
                  error_cnt++;
               end
            end
            got++;
         end
         @(posedge clk);
         #1;
      end
      ready[c] = 1'b1;
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      void'($urandom(32'hb1e8));
      rst_n = 1'b0;
      req   = '0;
      ready = '1;
      for (int c = 0; c < `APU_NB_CORES; c++) begin
         apu_class[c] = APU_CLASS_MULT;
         opcode[c]    = OP_LOW;
         operand_a[c] = '0;
         operand_b[c] = '0;
      end
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_idle_outputs(2);
      // Request and result sides run apart so requests can overlap results
      for (int k = 0; k < `APU_NB_CORES; k++) begin
         fork
            automatic int c = k;
            issue_requests(c);
            collect_results(c);
         join_none
      end
      wait fork;
      repeat (2) @(posedge clk);
      $display("Checks %0d, value errors %0d, assertion failures %0d",
               check_cnt, error_cnt, apu_cluster_inst.checker_inst.fail_cnt);
      if (error_cnt == 0 && apu_cluster_inst.checker_inst.fail_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the cores did not finish their transactions in time");
      $display("Test failed");
      $finish;
   end

endmodule

// ==== verilog/apu_arbiter.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_arbiter (
   input  logic                     clk,
   input  logic                     rst_n,
   // Core side of one class
   input  apu_route_pkg::core_vec_t class_req,
   input  logic [`APU_DATA_W-1:0]   op_a         [`APU_NB_CORES-1:0],
   input  logic [`APU_DATA_W-1:0]   op_b         [`APU_NB_CORES-1:0],
   input  apu_op_pkg::apu_opcode_e  op_code      [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t class_ack,
   output apu_route_pkg::core_vec_t class_valid,
   output logic [`APU_DATA_W-1:0]   class_result [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t class_status,
   input  apu_route_pkg::core_vec_t class_ready,
   // Unit input
   output logic                     in_valid,
   input  logic                     in_ready,
   output apu_route_pkg::core_tag_t in_tag,
   output logic [`APU_DATA_W-1:0]   in_a,
   output logic [`APU_DATA_W-1:0]   in_b,
   output apu_op_pkg::apu_opcode_e  in_op,
   // Unit output
   input  logic                     out_valid,
   output logic                     out_ready,
   input  apu_route_pkg::core_tag_t out_tag,
   input  logic [`APU_DATA_W-1:0]   out_result,
   input  logic                     out_status
);
   import apu_route_pkg::*;

   // Core with highest priority next
   core_tag_t rr_ptr;
   // Winner of this cycle
   core_tag_t grant;
   // Item handed to the unit
   logic      xfer;

   ////////////////////
   // Round robin
   ////////////////////

   // Scan from the far end so the nearest requester to the pointer wins
   always_comb begin
      core_tag_t idx;
      grant = rr_ptr;
      for (int k = `APU_NB_CORES - 1; k >= 0; k--) begin
         idx = rr_ptr + core_tag_t'(k);
         if (class_req[idx]) begin
            grant = idx;
         end
      end
   end

   assign in_valid = |class_req;
   assign xfer     = in_valid && in_ready;

   // Pointer moves one past the winner
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rr_ptr <= '0;
      end else if (xfer) begin
         rr_ptr <= grant + core_tag_t'(1);
      end
   end

   ////////////////////
   // Toward the unit
   ////////////////////

   // Core index becomes the tag
   assign in_tag = grant;
   assign in_a   = op_a[grant];
   assign in_b   = op_b[grant];
   assign in_op  = op_code[grant];

   // Ack only the granted core and only on transfer
   always_comb begin
      class_ack        = '0;
      class_ack[grant] = xfer;
   end

   ////////////////////
   // Back to cores
   ////////////////////

   // Tag decode onto the owner's lines
   // Result word is broadcast and qualified by valid
   always_comb begin
      for (int i = 0; i < `APU_NB_CORES; i++) begin
         class_valid[i]  = out_valid && (out_tag == core_tag_t'(i));
         class_status[i] = class_valid[i] && out_status;
         class_result[i] = out_result;
      end
   end

   // Owner's ready releases the unit
   assign out_ready = class_ready[out_tag];

endmodule

// ==== verilog/apu_cluster.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_cluster (
   input  logic                     clk,
   input  logic                     rst_n,
   // Core request side
   input  apu_route_pkg::core_vec_t req,
   input  apu_op_pkg::apu_class_e   apu_class [`APU_NB_CORES-1:0],
   input  apu_op_pkg::apu_opcode_e  opcode    [`APU_NB_CORES-1:0],
   input  logic [`APU_DATA_W-1:0]   operand_a [`APU_NB_CORES-1:0],
   input  logic [`APU_DATA_W-1:0]   operand_b [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t ack,
   // Core result side
   output apu_route_pkg::core_vec_t valid,
   input  apu_route_pkg::core_vec_t ready,
   output logic [`APU_DATA_W-1:0]   result    [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t status
);
   import apu_op_pkg::*;
   import apu_route_pkg::*;

   ////////////////////
   // Wires
   ////////////////////

   // Request fields seen by both arbiters
   logic [`APU_DATA_W-1:0] op_a    [`APU_NB_CORES-1:0];
   logic [`APU_DATA_W-1:0] op_b    [`APU_NB_CORES-1:0];
   apu_opcode_e            op_code [`APU_NB_CORES-1:0];

   // Dispatch to multiplier arbiter
   core_vec_t              mult_req;
   core_vec_t              mult_ack;
   core_vec_t              mult_valid;
   logic [`APU_DATA_W-1:0] mult_result [`APU_NB_CORES-1:0];
   core_vec_t              mult_status;
   core_vec_t              mult_ready;

   // Dispatch to divider arbiter
   core_vec_t              div_req;
   core_vec_t              div_ack;
   core_vec_t              div_valid;
   logic [`APU_DATA_W-1:0] div_result [`APU_NB_CORES-1:0];
   core_vec_t              div_status;
   core_vec_t              div_ready;

   // Multiplier arbiter to unit
   logic                   mult_in_valid;
   logic                   mult_in_ready;
   core_tag_t              mult_in_tag;
   logic [`APU_DATA_W-1:0] mult_in_a;
   logic [`APU_DATA_W-1:0] mult_in_b;
   apu_opcode_e            mult_in_op;
   logic                   mult_out_valid;
   logic                   mult_out_ready;
   core_tag_t              mult_out_tag;
   logic [`APU_DATA_W-1:0] mult_out_result;
   logic                   mult_out_status;

   // Divider arbiter to unit
   logic                   div_in_valid;
   logic                   div_in_ready;
   core_tag_t              div_in_tag;
   logic [`APU_DATA_W-1:0] div_in_a;
   logic [`APU_DATA_W-1:0] div_in_b;
   apu_opcode_e            div_in_op;
   logic                   div_out_valid;
   logic                   div_out_ready;
   core_tag_t              div_out_tag;
   logic [`APU_DATA_W-1:0] div_out_result;
   logic                   div_out_status;

   ////////////////////
   // Dispatch
   ////////////////////

   // Port and wire names line up one to one
   apu_dispatch dispatch_inst (.*);

   ////////////////////
   // Arbiters
   ////////////////////

   apu_arbiter arb_mult (
      .clk          (clk),
      .rst_n        (rst_n),
      .class_req    (mult_req),
      .op_a         (op_a),
      .op_b         (op_b),
      .op_code      (op_code),
      .class_ack    (mult_ack),
      .class_valid  (mult_valid),
      .class_result (mult_result),
      .class_status (mult_status),
      .class_ready  (mult_ready),
      .in_valid     (mult_in_valid),
      .in_ready     (mult_in_ready),
      .in_tag       (mult_in_tag),
      .in_a         (mult_in_a),
      .in_b         (mult_in_b),
      .in_op        (mult_in_op),
      .out_valid    (mult_out_valid),
      .out_ready    (mult_out_ready),
      .out_tag      (mult_out_tag),
      .out_result   (mult_out_result),
      .out_status   (mult_out_status)
   );

   apu_arbiter arb_div (
      .clk          (clk),
      .rst_n        (rst_n),
      .class_req    (div_req),
      .op_a         (op_a),
      .op_b         (op_b),
      .op_code      (op_code),
      .class_ack    (div_ack),
      .class_valid  (div_valid),
      .class_result (div_result),
      .class_status (div_status),
      .class_ready  (div_ready),
      .in_valid     (div_in_valid),
      .in_ready     (div_in_ready),
      .in_tag       (div_in_tag),
      .in_a         (div_in_a),
      .in_b         (div_in_b),
      .in_op        (div_in_op),
      .out_valid    (div_out_valid),
      .out_ready    (div_out_ready),
      .out_tag      (div_out_tag),
      .out_result   (div_out_result),
      .out_status   (div_out_status)
   );

   ////////////////////
   // Shared units
   ////////////////////

   int_mult_unit mult_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (mult_in_valid),
      .in_ready   (mult_in_ready),
      .in_tag     (mult_in_tag),
      .in_a       (mult_in_a),
      .in_b       (mult_in_b),
      .in_op      (mult_in_op),
      .out_valid  (mult_out_valid),
      .out_ready  (mult_out_ready),
      .out_tag    (mult_out_tag),
      .out_result (mult_out_result),
      .out_status (mult_out_status)
   );

   int_div_unit div_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (div_in_valid),
      .in_ready   (div_in_ready),
      .in_tag     (div_in_tag),
      .in_a       (div_in_a),
      .in_b       (div_in_b),
      .in_op      (div_in_op),
      .out_valid  (div_out_valid),
      .out_ready  (div_out_ready),
      .out_tag    (div_out_tag),
      .out_result (div_out_result),
      .out_status (div_out_status)
   );

endmodule

// ==== verilog/apu_dispatch.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_dispatch (
   input  logic                     clk,
   input  logic                     rst_n,
   // Core side
   input  apu_route_pkg::core_vec_t req,
   input  apu_op_pkg::apu_class_e   apu_class   [`APU_NB_CORES-1:0],
   input  apu_op_pkg::apu_opcode_e  opcode      [`APU_NB_CORES-1:0],
   input  logic [`APU_DATA_W-1:0]   operand_a   [`APU_NB_CORES-1:0],
   input  logic [`APU_DATA_W-1:0]   operand_b   [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t ack,
   output apu_route_pkg::core_vec_t valid,
   input  apu_route_pkg::core_vec_t ready,
   output logic [`APU_DATA_W-1:0]   result      [`APU_NB_CORES-1:0],
   output apu_route_pkg::core_vec_t status,
   // Request fields shared by both classes
   output logic [`APU_DATA_W-1:0]   op_a        [`APU_NB_CORES-1:0],
   output logic [`APU_DATA_W-1:0]   op_b        [`APU_NB_CORES-1:0],
   output apu_op_pkg::apu_opcode_e  op_code     [`APU_NB_CORES-1:0],
   // Multiplier class
   output apu_route_pkg::core_vec_t mult_req,
   input  apu_route_pkg::core_vec_t mult_ack,
   input  apu_route_pkg::core_vec_t mult_valid,
   input  logic [`APU_DATA_W-1:0]   mult_result [`APU_NB_CORES-1:0],
   input  apu_route_pkg::core_vec_t mult_status,
   output apu_route_pkg::core_vec_t mult_ready,
   // Divider class
   output apu_route_pkg::core_vec_t div_req,
   input  apu_route_pkg::core_vec_t div_ack,
   input  apu_route_pkg::core_vec_t div_valid,
   input  logic [`APU_DATA_W-1:0]   div_result  [`APU_NB_CORES-1:0],
   input  apu_route_pkg::core_vec_t div_status,
   output apu_route_pkg::core_vec_t div_ready
);
   import apu_op_pkg::*;
   import apu_route_pkg::*;

   // Core waits on a result
   core_vec_t pending;
   // Result handed over this cycle
   core_vec_t done;
   // Core may issue this cycle
   core_vec_t free;

   assign done = valid & ready;
   // Same-cycle handover frees the core at once
   assign free = ~pending | done;

   ////////////////////
   // Outstanding bits
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= '0;
      end else begin
         // New ack wins over a handover in the same cycle
         pending <= ack | (pending & ~done);
      end
   end

   ////////////////////
   // Downstream
   ////////////////////

   // Steer by class
   always_comb begin
      for (int i = 0; i < `APU_NB_CORES; i++) begin
         mult_req[i] = req[i] && free[i] && (apu_class[i] == APU_CLASS_MULT);
         div_req[i]  = req[i] && free[i] && (apu_class[i] == APU_CLASS_DIV);
      end
   end

   assign op_a    = operand_a;
   assign op_b    = operand_b;
   assign op_code = opcode;

   // At most one class acks a core
   assign ack = mult_ack | div_ack;

   ////////////////////
   // Upstream
   ////////////////////

   // Only one class can hold a result per core
   always_comb begin
      for (int i = 0; i < `APU_NB_CORES; i++) begin
         valid[i]  = mult_valid[i] | div_valid[i];
         result[i] = div_valid[i] ? div_result[i] : mult_result[i];
         status[i] = div_valid[i] ? div_status[i] : mult_status[i];
      end
   end

   // Ready back to the class that holds the result
   assign mult_ready = ready & mult_valid;
   assign div_ready  = ready & div_valid;

endmodule

// ==== verilog/apu_op_pkg.sv ====
package apu_op_pkg;

   ////////////////////
   // Operation class
   ////////////////////

   // Picks which shared unit serves the request
   typedef enum logic {
      APU_CLASS_MULT = 1'b0,
      APU_CLASS_DIV  = 1'b1
   } apu_class_e;

   ////////////////////
   // Opcode
   ////////////////////

   // Multiply returns the low or high product word
   // Divide returns the quotient or the remainder
   typedef enum logic {
      OP_LOW  = 1'b0,
      OP_HIGH = 1'b1
   } apu_opcode_e;

endpackage

// ==== verilog/apu_route_pkg.sv ====
`include "apu_defines.svh"

package apu_route_pkg;

   // Issuing core index
   // Rides along with every item inside a unit
   typedef logic [`APU_TAG_W-1:0] core_tag_t;

   // One bit per core
   // Used for req, ack, valid, ready and status
   typedef logic [`APU_NB_CORES-1:0] core_vec_t;

endpackage

// ==== verilog/int_div_unit.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module int_div_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  apu_route_pkg::core_tag_t in_tag,
   input  logic [`APU_DATA_W-1:0]   in_a,
   input  logic [`APU_DATA_W-1:0]   in_b,
   input  apu_op_pkg::apu_opcode_e  in_op,
   output logic                     out_valid,
   input  logic                     out_ready,
   output apu_route_pkg::core_tag_t out_tag,
   output logic [`APU_DATA_W-1:0]   out_result,
   output logic                     out_status
);
   import apu_op_pkg::*;
   import apu_route_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      CALC,
      DONE
   } div_state_e;

   div_state_e                         state;
   logic [$clog2(`APU_DIV_CYCLES)-1:0] cnt;

   // Dividend shifts out of quo as quotient bits shift in
   logic [`APU_DATA_W-1:0]             quo;
   logic [`APU_DATA_W-1:0]             rem;
   logic [`APU_DATA_W-1:0]             dvsr;
   // Partial remainder with next dividend bit
   logic [`APU_DATA_W:0]               trial;
   logic [`APU_DATA_W:0]               diff;
   logic                               ge;
   // Divide by zero seen at accept
   logic                               dbz;
   core_tag_t                          tag_q;
   apu_opcode_e                        op_q;

   assign trial = {rem, quo[`APU_DATA_W-1]};
   assign diff  = trial - {1'b0, dvsr};
   assign ge    = (trial >= {1'b0, dvsr});

   ////////////////////
   // Control FSM
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (in_valid) begin
                  state <= CALC;
                  cnt   <= '0;
               end
            end
            CALC: begin
               cnt <= cnt + 1'b1;
               // Last quotient bit this cycle
               if (cnt == `APU_DIV_CYCLES - 1) begin
                  state <= DONE;
               end
            end
            DONE: begin
               if (out_ready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Restoring step
   ////////////////////

   // Zero divisor needs no special path
   // Every step subtracts nothing, so quo ends all ones and rem ends as the dividend
   always_ff @(posedge clk) begin
      if (state == IDLE && in_valid) begin
         quo   <= in_a;
         rem   <= '0;
         dvsr  <= in_b;
         dbz   <= (in_b == '0);
         tag_q <= in_tag;
         op_q  <= in_op;
      end else if (state == CALC) begin
         rem <= ge ? diff[`APU_DATA_W-1:0] : trial[`APU_DATA_W-1:0];
         quo <= {quo[`APU_DATA_W-2:0], ge};
      end
   end

   // Busy from accept until the result is taken
   assign in_ready   = (state == IDLE);
   assign out_valid  = (state == DONE);
   assign out_tag    = tag_q;
   assign out_result = (op_q == OP_HIGH) ? rem : quo;
   assign out_status = dbz;

endmodule

// ==== verilog/int_mult_unit.sv ====
`timescale 1ns/1ps
`include "apu_defines.svh"

module int_mult_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  apu_route_pkg::core_tag_t in_tag,
   input  logic [`APU_DATA_W-1:0]   in_a,
   input  logic [`APU_DATA_W-1:0]   in_b,
   input  apu_op_pkg::apu_opcode_e  in_op,
   output logic                     out_valid,
   input  logic                     out_ready,
   output apu_route_pkg::core_tag_t out_tag,
   output logic [`APU_DATA_W-1:0]   out_result,
   output logic                     out_status
);
   import apu_op_pkg::*;
   import apu_route_pkg::*;

   // Stage valids, index 0 is the input register
   logic [`APU_MULT_STAGES-1:0] vld;
   core_tag_t                   tag_q [`APU_MULT_STAGES-1:0];
   // Opcode is consumed at the word select
   apu_opcode_e                 op_q  [`APU_MULT_STAGES-2:0];

   // Stage 1 operands
   logic [`APU_DATA_W-1:0]      a_q;
   logic [`APU_DATA_W-1:0]      b_q;
   // Stage 2 full product
   logic [2*`APU_DATA_W-1:0]    prod_q;
   // Stage 3 selected word
   logic [`APU_DATA_W-1:0]      res_q;

   logic                        stall;

   // Output held and not taken freezes every stage
   assign stall    = vld[`APU_MULT_STAGES-1] && !out_ready;
   assign in_ready = !stall;

   ////////////////////
   // Valid chain
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld <= '0;
      end else if (!stall) begin
         vld <= {vld[`APU_MULT_STAGES-2:0], in_valid};
      end
   end

   ////////////////////
   // Datapath
   ////////////////////

   always_ff @(posedge clk) begin
      if (!stall) begin
         a_q      <= in_a;
         b_q      <= in_b;
         tag_q[0] <= in_tag;
         op_q[0]  <= in_op;
         for (int s = 1; s < `APU_MULT_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
         end
         op_q[1]  <= op_q[0];
         // Unsigned 32x32 product
         prod_q   <= a_q * b_q;
         // High or low word
         res_q    <= (op_q[1] == OP_HIGH) ? prod_q[2*`APU_DATA_W-1:`APU_DATA_W]
                                          : prod_q[`APU_DATA_W-1:0];
      end
   end

   assign out_valid  = vld[`APU_MULT_STAGES-1];
   assign out_tag    = tag_q[`APU_MULT_STAGES-1];
   assign out_result = res_q;
   // Multiply never faults
   assign out_status = 1'b0;

endmodule
